// ==== logic/mipsPkg.sv ====
// shared types for the single-cycle MIPS32 subset core
// only the opcodes and function codes listed here are decoded
// anything else runs as a no-op
`default_nettype none

package mipsPkg;

  // register index width, 32 architectural registers
  localparam int RegAddrWidth = 5;

  // ====================
  // instruction encodings
  // ====================
  typedef enum logic [5:0] {
    opSpecial = 6'b000000,
    opJ       = 6'b000010,
    opJal     = 6'b000011,
    opBeq     = 6'b000100,
    opLw      = 6'b100011,
    opSw      = 6'b101011
  } opcodeT;

  // funct field, only looked at when opcode is special
  typedef enum logic [5:0] {
    fnJr  = 6'b001000,
    fnAdd = 6'b100000,
    fnSub = 6'b100010,
    fnAnd = 6'b100100,
    fnOr  = 6'b100101,
    fnSlt = 6'b101010
  } functT;

  // ALU operations, aluNone gives a zero result
  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluSlt,
    aluNone
  } aluOpT;

  // ====================
  // control word
  // ====================
  typedef struct packed {
    logic  regDst;     // write rd instead of rt
    logic  aluSrcImm;  // operand b from immediate
    logic  memToReg;   // write back load data
    logic  regWrite;
    logic  memRead;
    logic  memWrite;
    logic  branch;
    logic  jump;
    logic  link;       // jal, r31 gets pc+8
    logic  jumpReg;    // jr
    aluOpT aluOp;
  } ctrlWordT;

endpackage

`default_nettype wire

// ==== logic/regFileIf.sv ====
// register file bus inside the core
// two combinational read ports, one write port taken at the clock edge
`timescale 1ns/1ps
`default_nettype none

interface regFileIf;
  import mipsPkg::*;

  // read side
  logic [RegAddrWidth-1:0] rdAddrA;
  logic [RegAddrWidth-1:0] rdAddrB;
  logic [31:0]             rdDataA;
  logic [31:0]             rdDataB;

  // write side
  logic                    wrEn;
  logic [RegAddrWidth-1:0] wrAddr;
  logic [31:0]             wrData;

  // datapath side drives addresses and write data
  modport core (output rdAddrA, rdAddrB, wrEn, wrAddr, wrData, input rdDataA, rdDataB);

  // storage side answers the reads
  modport regs (input rdAddrA, rdAddrB, wrEn, wrAddr, wrData, output rdDataA, rdDataB);

endinterface

`default_nettype wire

// ==== logic/controlDecoder.sv ====
// main decoder plus the R-type ALU control step, purely combinational
// unknown opcode or funct gives an all-inactive word, i.e. a no-op
`timescale 1ns/1ps
`default_nettype none

module controlDecoder (
  input  mipsPkg::opcodeT   opcode,
  input  mipsPkg::functT    funct,
  output mipsPkg::ctrlWordT ctrl
);
  import mipsPkg::*;

  always_comb begin
    // default is a no-op
    ctrl       = '0;
    ctrl.aluOp = aluNone;
    case (opcode)
      opSpecial: begin
        // R-type, funct picks the ALU op
        case (funct)
          fnAdd: ctrl.aluOp = aluAdd;
          fnSub: ctrl.aluOp = aluSub;
          fnAnd: ctrl.aluOp = aluAnd;
          fnOr:  ctrl.aluOp = aluOr;
          fnSlt: ctrl.aluOp = aluSlt;
          default: ctrl.aluOp = aluNone;
        endcase
        ctrl.regDst   = (ctrl.aluOp != aluNone);
        ctrl.regWrite = (ctrl.aluOp != aluNone);
        // jr only redirects the pc
        ctrl.jumpReg  = (funct == fnJr);
      end
      opLw: begin
        ctrl.aluSrcImm = 1'b1;
        ctrl.memToReg  = 1'b1;
        ctrl.regWrite  = 1'b1;
        ctrl.memRead   = 1'b1;
        ctrl.aluOp     = aluAdd;
      end
      opSw: begin
        ctrl.aluSrcImm = 1'b1;
        ctrl.memWrite  = 1'b1;
        ctrl.aluOp     = aluAdd;
      end
      // compare by subtraction, zero flag decides
      opBeq: begin
        ctrl.branch = 1'b1;
        ctrl.aluOp  = aluSub;
      end
      opJ: ctrl.jump = 1'b1;
      opJal: begin
        ctrl.jump     = 1'b1;
        ctrl.link     = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      default: ctrl.aluOp = aluNone;
    endcase
  end

  // next-pc priority relies on never seeing both at once
  always_comb begin
    assert final (!(ctrl.jump && ctrl.branch))
      else $error("decoder raised jump and branch together");
  end

endmodule

`default_nettype wire

// ==== logic/alu.sv ====
// 32-bit ALU for the core subset
// slt compares signed, zero flag follows the result for every op
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  logic [31:0]    a,
  input  logic [31:0]    b,
  input  mipsPkg::aluOpT op,
  output logic [31:0]    result,
  output logic           zero
);
  import mipsPkg::*;

  logic signedLess;

  // signed compare for slt
  assign signedLess = ($signed(a) < $signed(b));

  always_comb begin
    case (op)
      aluAdd: begin
        result = a + b;
      end
      aluSub: begin
        // beq uses this one
        result = a - b;
      end
      aluAnd: begin
        result = a & b;
      end
      aluOr: begin
        result = a | b;
      end
      aluSlt: begin
        result = {31'b0, signedLess};
      end
      default: begin
        // aluNone and anything unexpected
        result = '0;
      end
    endcase
  end

  // high whenever result is all zero
  assign zero = (result == '0);

endmodule

`default_nettype wire

// ==== logic/registerFile.sv ====
// 32 x 32 general register file
// reads are combinational and writes land on the rising clock edge
// register 0 ignores writes and always reads as zero
`timescale 1ns/1ps
`default_nettype none

module registerFile (
  input logic    clk,
  input logic    rst,
  regFileIf.regs rf
);
  import mipsPkg::*;

  localparam int Depth = 1 << RegAddrWidth;

  logic [31:0] regs [Depth];

  // ====================
  // write port
  // ====================
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      // clear every register
      for (int i = 0; i < Depth; i++) begin
        regs[i] <= '0;
      end
    end else if (rf.wrEn && (rf.wrAddr != '0)) begin
      regs[rf.wrAddr] <= rf.wrData;
    end
  end

  // ====================
  // read ports
  // ====================
  // r0 forced to zero on both ports
  assign rf.rdDataA = (rf.rdAddrA == '0) ? '0 : regs[rf.rdAddrA];
  assign rf.rdDataB = (rf.rdAddrB == '0) ? '0 : regs[rf.rdAddrB];

  // r0 storage stays zero after every edge
  assert property (@(posedge clk) disable iff (!rst) regs[0] == '0)
    else $error("register 0 picked up a write");

endmodule

`default_nettype wire

// ==== logic/nextPcUnit.sv ====
// program counter and next-address choice
// priority: jump, taken branch, register jump, then pc+4
// pc clears to 0 on reset, no delay slot
`timescale 1ns/1ps
`default_nettype none

module nextPcUnit (
  input  logic        clk,
  input  logic        rst,
  input  logic        branch,
  input  logic        zero,
  input  logic        jump,
  input  logic        jumpReg,
  input  logic [31:0] immWord,
  input  logic [25:0] target,
  input  logic [31:0] regTarget,
  output logic [31:0] pc,
  output logic [31:0] pcPlus8
);

  logic [31:0] pcPlus4;
  logic [31:0] branchAddr;
  logic [31:0] jumpAddr;
  logic        takeBranch;
  logic [31:0] pcNext;

  // ====================
  // candidate addresses
  // ====================
  assign pcPlus4    = pc + 32'd4;
  assign pcPlus8    = pc + 32'd8;
  // offset in words, relative to pc+4
  assign branchAddr = pcPlus4 + {immWord[29:0], 2'b00};
  // region bits kept from pc+4
  assign jumpAddr   = {pcPlus4[31:28], target, 2'b00};
  assign takeBranch = branch && zero;

  always_comb begin
    if (jump) begin
      pcNext = jumpAddr;
    end else if (takeBranch) begin
      pcNext = branchAddr;
    end else if (jumpReg) begin
      pcNext = regTarget;
    end else begin
      pcNext = pcPlus4;
    end
  end

  // pc register
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= '0;
    end else begin
      pc <= pcNext;
    end
  end

  // jr takes rs as is, so a bad register value would show here
  assert property (@(posedge clk) disable iff (!rst) pc[1:0] == 2'b00)
    else $error("pc lost word alignment");

endmodule

`default_nettype wire

// ==== logic/mipsCore.sv ====
// single-cycle MIPS32 subset core, one instruction retires per clock
// instruction and data memories sit outside and answer in the same cycle
// data memory is word addressed, DataAddrWidth bits of word index
// regWrEn is held low during reset
`timescale 1ns/1ps
`default_nettype none

module mipsCore #(
  parameter int DataAddrWidth = 7
) (
  input  logic                     clk,
  input  logic                     rst,
  output logic [31:0]              instrAddr,
  input  logic [31:0]              instr,
  output logic [DataAddrWidth-1:0] dataAddr,
  output logic [31:0]              dataWrData,
  input  logic [31:0]              dataRdData,
  output logic                     dataRdEn,
  output logic                     dataWrEn,
  output logic [31:0]              regWrData,
  output logic                     regWrEn
);
  import mipsPkg::*;

  // ====================
  // instruction fields
  // ====================
  opcodeT                  opcode;
  functT                   funct;
  logic [RegAddrWidth-1:0] rs;
  logic [RegAddrWidth-1:0] rt;
  logic [RegAddrWidth-1:0] rd;
  logic [31:0]             immWord;
  logic [RegAddrWidth-1:0] destReg;

  ctrlWordT    ctrl;
  logic [31:0] aluB;
  logic [31:0] aluResult;
  logic        aluZero;
  logic [31:0] pcPlus8;

  regFileIf rfBus ();

  assign opcode  = opcodeT'(instr[31:26]);
  assign funct   = functT'(instr[5:0]);
  assign rs      = instr[25:21];
  assign rt      = instr[20:16];
  assign rd      = instr[15:11];
  // sign extend the 16-bit immediate
  assign immWord = {{16{instr[15]}}, instr[15:0]};

  controlDecoder uDecoder (
    .opcode (opcode),
    .funct  (funct),
    .ctrl   (ctrl)
  );

  registerFile uRegs (
    .clk (clk),
    .rst (rst),
    .rf  (rfBus.regs)
  );

  // operand b: rt or immediate
  assign aluB = ctrl.aluSrcImm ? immWord : rfBus.rdDataB;

  alu uAlu (
    .a      (rfBus.rdDataA),
    .b      (aluB),
    .op     (ctrl.aluOp),
    .result (aluResult),
    .zero   (aluZero)
  );

  nextPcUnit uNextPc (
    .clk       (clk),
    .rst       (rst),
    .branch    (ctrl.branch),
    .zero      (aluZero),
    .jump      (ctrl.jump),
    .jumpReg   (ctrl.jumpReg),
    .immWord   (immWord),
    .target    (instr[25:0]),
    .regTarget (rfBus.rdDataA),
    .pc        (instrAddr),
    .pcPlus8   (pcPlus8)
  );

  // ====================
  // write back
  // ====================
  // jal goes to r31, R-type to rd, lw to rt
  assign destReg   = ctrl.link ? RegAddrWidth'(31) : (ctrl.regDst ? rd : rt);
  assign regWrData = ctrl.link ? pcPlus8 : (ctrl.memToReg ? dataRdData : aluResult);
  // r0 writes never show as a write
  assign regWrEn   = rst && ctrl.regWrite && (destReg != '0);

  assign rfBus.rdAddrA = rs;
  assign rfBus.rdAddrB = rt;
  assign rfBus.wrEn    = regWrEn;
  assign rfBus.wrAddr  = destReg;
  assign rfBus.wrData  = regWrData;

  // data memory, word index from byte address
  assign dataAddr   = aluResult[DataAddrWidth+1:2];
  assign dataWrData = rfBus.rdDataB;
  assign dataRdEn   = ctrl.memRead;
  assign dataWrEn   = ctrl.memWrite;

endmodule

`default_nettype wire

// ==== tb/clockGen.sv ====
// free running testbench clock, starts low
// period fixed by HalfPeriod, in ns
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
  parameter int HalfPeriod = 20
) (
  output logic clk
);

  initial clk = 1'b0;

  // 40 ns period by default
  always #(HalfPeriod) clk = ~clk;

endmodule

`default_nettype wire

// ==== tb/mipsCoreTb.sv ====
// directed tests for the single-cycle core
// instruction memory is 1024 words, so fetch addresses must stay below 4 KB
// data memory is 128 words, word index taken from dataAddr
// stops at the first mismatch or pc timeout
`timescale 1ns/1ps
`default_nettype none

module mipsCoreTb;

  localparam int DataAddrWidth = 7;

  // MIPS32 encodings
  localparam logic [5:0] OpLw   = 6'h23;
  localparam logic [5:0] OpSw   = 6'h2b;
  localparam logic [5:0] OpBeq  = 6'h04;
  localparam logic [5:0] OpJ    = 6'h02;
  localparam logic [5:0] OpJal  = 6'h03;
  localparam logic [5:0] FnAdd  = 6'h20;
  localparam logic [5:0] FnSub  = 6'h22;
  localparam logic [5:0] FnAnd  = 6'h24;
  localparam logic [5:0] FnOr   = 6'h25;
  localparam logic [5:0] FnSlt  = 6'h2a;
  localparam logic [5:0] FnJr   = 6'h08;

  logic                     clk;
  logic                     rst;
  logic [31:0]              instrAddr;
  logic [31:0]              instr;
  logic [DataAddrWidth-1:0] dataAddr;
  logic [31:0]              dataWrData;
  logic [31:0]              dataRdData;
  logic                     dataRdEn;
  logic                     dataWrEn;
  logic [31:0]              regWrData;
  logic                     regWrEn;

  // memory models and reference state
  logic [31:0] imem [1024];
  logic [31:0] dmem [1 << DataAddrWidth];
  logic [31:0] refMem [1 << DataAddrWidth];
  logic [31:0] refRegs [32];
  logic [31:0] refPc;
  logic [15:0] lfsr;

  clockGen #(.HalfPeriod(20)) uClock (.clk(clk));

  mipsCore #(.DataAddrWidth(DataAddrWidth)) dut (
    .clk        (clk),
    .rst        (rst),
    .instrAddr  (instrAddr),
    .instr      (instr),
    .dataAddr   (dataAddr),
    .dataWrData (dataWrData),
    .dataRdData (dataRdData),
    .dataRdEn   (dataRdEn),
    .dataWrEn   (dataWrEn),
    .regWrData  (regWrData),
    .regWrEn    (regWrEn)
  );

  // ====================
  // memories
  // ====================
  // all-zero word during reset decodes as a no-op
  assign instr      = rst ? imem[instrAddr[11:2]] : 32'h0;
  assign dataRdData = dmem[dataAddr];

  always @(posedge clk) begin
    if (dataWrEn) begin
      dmem[dataAddr] <= dataWrData;
    end
  end

  // ====================
  // helpers
  // ====================
  function automatic logic [31:0] rTypeWord(input logic [5:0] fn, input logic [4:0] rd,
                                            input logic [4:0] rs, input logic [4:0] rt);
    return {6'h00, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] iTypeWord(input logic [5:0] op, input logic [4:0] rs,
                                            input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] jTypeWord(input logic [5:0] op, input logic [25:0] target);
    return {op, target};
  endfunction

  // fibonacci LFSR with taps 16 14 13 11
  function automatic logic lfsrBit();
    logic fb;
    fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] randWord();
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < 32; i++) begin
      v = {v[30:0], lfsrBit()};
    end
    return v;
  endfunction

  task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("FAIL at %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  // each step lands 5 ns after the rising edge
  task automatic waitPc(input logic [31:0] target, input int limit);
    int n;
    n = 0;
    while (n < limit) begin
      @(posedge clk);
      #5;
      n++;
      if (instrAddr === target) begin
        break;
      end
    end
    if (instrAddr !== target) begin
      $display("timeout: pc never reached %h within %0d cycles, pc is %h",
               target, limit, instrAddr);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  // ====================
  // one instruction against the reference model
  // ====================
  task automatic exec(input logic [31:0] w);
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  dest;
    logic [31:0] imm;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] addr;
    logic [31:0] pc4;
    logic [31:0] expData;
    logic [31:0] expNext;
    logic        expWrite;
    logic        expRdEn;
    logic        expWrEn;
    rs       = w[25:21];
    rt       = w[20:16];
    imm      = {{16{w[15]}}, w[15:0]};
    a        = refRegs[rs];
    b        = refRegs[rt];
    addr     = a + imm;
    pc4      = refPc + 32'd4;
    expNext  = pc4;
    expData  = '0;
    dest     = '0;
    expWrite = 1'b0;
    expRdEn  = 1'b0;
    expWrEn  = 1'b0;
    case (w[31:26])
      6'h00: begin
        dest     = w[15:11];
        expWrite = 1'b1;
        case (w[5:0])
          FnAdd: expData = a + b;
          FnSub: expData = a - b;
          FnAnd: expData = a & b;
          FnOr:  expData = a | b;
          FnSlt: expData = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          FnJr: begin
            expWrite = 1'b0;
            expNext  = a;
          end
          default: expWrite = 1'b0;
        endcase
      end
      OpLw: begin
        dest     = rt;
        expWrite = 1'b1;
        expRdEn  = 1'b1;
        expData  = refMem[addr[DataAddrWidth+1:2]];
      end
      OpSw: expWrEn = 1'b1;
      OpBeq: begin
        if (a == b) begin
          expNext = pc4 + (imm << 2);
        end
      end
      OpJ: expNext = {pc4[31:28], w[25:0], 2'b00};
      OpJal: begin
        expNext  = {pc4[31:28], w[25:0], 2'b00};
        dest     = 5'd31;
        expWrite = 1'b1;
        expData  = refPc + 32'd8;
      end
      default: expWrite = 1'b0;
    endcase
    // r0 is never written
    if (dest == 5'd0) begin
      expWrite = 1'b0;
    end
    imem[refPc[11:2]] = w;
    #1;
    checkEq(instrAddr, refPc, "instrAddr");
    checkEq(regWrEn, expWrite, "regWrEn");
    checkEq(dataRdEn, expRdEn, "dataRdEn");
    checkEq(dataWrEn, expWrEn, "dataWrEn");
    if (expWrite) begin
      checkEq(regWrData, expData, "regWrData");
      refRegs[dest] = expData;
    end
    if (expRdEn || expWrEn) begin
      checkEq(dataAddr, addr[DataAddrWidth+1:2], "dataAddr");
    end
    if (expWrEn) begin
      checkEq(dataWrData, b, "dataWrData");
      refMem[addr[DataAddrWidth+1:2]] = b;
    end
    refPc = expNext;
    waitPc(expNext, 1);
  endtask

  // ====================
  // tests
  // ====================
  task automatic resetTest();
    rst = 1'b0;
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      #5;
      checkEq(instrAddr, 32'h0, "instrAddr in reset");
      checkEq(regWrEn, 1'b0, "regWrEn in reset");
    end
    rst = 1'b1;
    #1;
    checkEq(instrAddr, 32'h0, "instrAddr after reset");
    checkEq(regWrEn, 1'b0, "regWrEn after reset");
    refPc = 32'h0;
  endtask

  task automatic arithTest();
    logic [31:0] v;
    // r1..r6 from memory
    for (int i = 1; i <= 6; i++) begin
      v = randWord();
      // r3 and r4 negative for slt
      if (i == 3 || i == 4) begin
        v[31] = 1'b1;
      end
      // r1 positive so slt sees mixed signs
      if (i == 1) begin
        v[31] = 1'b0;
      end
      dmem[i]   = v;
      refMem[i] = v;
      exec(iTypeWord(OpLw, 5'd0, 5'(i), 16'(4 * i)));
    end
    exec(rTypeWord(FnAdd, 5'd7, 5'd1, 5'd2));
    exec(rTypeWord(FnSub, 5'd8, 5'd3, 5'd4));
    exec(rTypeWord(FnAnd, 5'd9, 5'd5, 5'd6));
    exec(rTypeWord(FnOr, 5'd10, 5'd1, 5'd3));
    exec(rTypeWord(FnSlt, 5'd11, 5'd3, 5'd1));
    exec(rTypeWord(FnSlt, 5'd12, 5'd1, 5'd3));
    exec(rTypeWord(FnSlt, 5'd13, 5'd3, 5'd4));
    exec(rTypeWord(FnSlt, 5'd20, 5'd4, 5'd3));
    // write to r0 and read r0 back
    exec(rTypeWord(FnAdd, 5'd0, 5'd1, 5'd2));
    exec(rTypeWord(FnAdd, 5'd14, 5'd0, 5'd1));
    exec(rTypeWord(FnOr, 5'd22, 5'd0, 5'd0));
  endtask

  task automatic memoryTest();
    // base register r15 = 64
    dmem[20]   = 32'd64;
    refMem[20] = 32'd64;
    exec(iTypeWord(OpLw, 5'd0, 5'd15, 16'd80));
    exec(iTypeWord(OpSw, 5'd15, 5'd8, 16'd12));
    exec(iTypeWord(OpSw, 5'd15, 5'd9, 16'hfff8));
    exec(iTypeWord(OpSw, 5'd0, 5'd7, 16'd200));
    exec(iTypeWord(OpLw, 5'd15, 5'd16, 16'd12));
    exec(iTypeWord(OpLw, 5'd15, 5'd17, 16'hfff8));
    exec(iTypeWord(OpLw, 5'd0, 5'd21, 16'd200));
  endtask

  task automatic branchTest();
    exec(iTypeWord(OpBeq, 5'd1, 5'd1, 16'd2));
    // unequal operands fall through
    exec(iTypeWord(OpBeq, 5'd1, 5'd3, 16'hfffb));
    // backward taken
    exec(iTypeWord(OpBeq, 5'd0, 5'd0, 16'hfffc));
    exec(iTypeWord(OpBeq, 5'd7, 5'd7, 16'd5));
  endtask

  task automatic jumpTest();
    logic [31:0] linkAddr;
    exec(jTypeWord(OpJ, 26'h200));
    checkEq(instrAddr, 32'h800, "j target");
    linkAddr = refPc + 32'd8;
    exec(jTypeWord(OpJal, 26'h180));
    exec(rTypeWord(FnAdd, 5'd18, 5'd1, 5'd2));
    // return through r31
    exec(rTypeWord(FnJr, 5'd0, 5'd31, 5'd0));
    checkEq(instrAddr, linkAddr, "jr return address");
  endtask

  task automatic unsupportedTest();
    // addi and an unused opcode
    exec(iTypeWord(6'h08, 5'd1, 5'd5, 16'h0010));
    exec(iTypeWord(6'h3f, 5'd2, 5'd6, 16'h1234));
    // sll and nor function codes
    exec(rTypeWord(6'h00, 5'd5, 5'd1, 5'd2));
    exec(rTypeWord(6'h27, 5'd6, 5'd1, 5'd2));
    exec(rTypeWord(FnOr, 5'd19, 5'd5, 5'd0));
  endtask

  // ====================
  // main sequence
  // ====================
  initial begin
    rst  = 1'b0;
    lfsr = 16'd16138;
    for (int i = 0; i < 1024; i++) begin
      imem[i] = 32'h0;
    end
    for (int i = 0; i < (1 << DataAddrWidth); i++) begin
      dmem[i]   = 32'hc3a50000 ^ (i << 20) ^ (i * 32'h0101);
      refMem[i] = 32'hc3a50000 ^ (i << 20) ^ (i * 32'h0101);
    end
    for (int i = 0; i < 32; i++) begin
      refRegs[i] = 32'h0;
    end
    resetTest();
    arithTest();
    memoryTest();
    branchTest();
    jumpTest();
    unsupportedTest();
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
logic/mipsPkg.sv
logic/regFileIf.sv
logic/controlDecoder.sv
logic/alu.sv
logic/registerFile.sv
logic/nextPcUnit.sv
logic/mipsCore.sv
tb/clockGen.sv
tb/mipsCoreTb.sv
